// File: design/alu.sv
module alu
   import uart_alu_pkg::*;
(
   input  logic [NB_DATA-1:0] i_a,
   input  logic [NB_DATA-1:0] i_b,
   input  alu_op_e            i_op,
   output logic [NB_DATA-1:0] o_result
);

   logic [2:0] shamt;

   // Shift amount from the low bits of B
   assign shamt = i_b[2:0];

   always_comb
   begin
      case (i_op)
         OP_ADD:
            o_result = i_a + i_b;
         OP_SUB:
            o_result = i_a - i_b;
         OP_AND:
            o_result = i_a & i_b;
         OP_OR:
            o_result = i_a | i_b;
         OP_XOR:
            o_result = i_a ^ i_b;
         OP_NOR:
            o_result = ~(i_a | i_b);
         OP_SRA:
            o_result = $signed(i_a) >>> shamt;
         OP_SRL:
            o_result = i_a >> shamt;
         // Undefined codes
         default:
            o_result = '0;
      endcase
   end

endmodule

// File: design/alu_interface.sv
module alu_interface
   import uart_alu_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_rx_done,
   input  logic [NB_DATA-1:0] i_rx_data,
   input  logic [NB_DATA-1:0] i_result,
   input  logic               i_tx_done,
   output logic [NB_DATA-1:0] o_a,
   output logic [NB_DATA-1:0] o_b,
   output alu_op_e            o_op,
   output logic               o_tx_start,
   output logic [NB_DATA-1:0] o_tx_data
);

   iface_state_e state_reg;
   logic         load_reg;
   alu_op_e      rx_op;

   // Bytes with high bits set map to an undefined code
   always_comb
   begin
      if (i_rx_data[NB_DATA-1:NB_OP] == '0)
         rx_op = alu_op_e'(i_rx_data[NB_OP-1:0]);
      else
         rx_op = alu_op_e'({NB_OP{1'b1}});
   end

   ////////////////////
   // Command sequencer

   always_ff @(posedge i_clk)
   begin
      if (!i_rst)
      begin
         state_reg  <= WAIT_A;
         load_reg   <= 1'b0;
         o_tx_start <= 1'b0;
      end
      else
      begin
         load_reg   <= 1'b0;
         // Start follows the result capture by one clock
         o_tx_start <= load_reg;
         case (state_reg)
            WAIT_A:
               if (i_rx_done)
                  state_reg <= WAIT_B;
            WAIT_B:
               if (i_rx_done)
                  state_reg <= WAIT_OP;
            WAIT_OP:
            begin
               if (i_rx_done)
               begin
                  state_reg <= SEND;
                  load_reg  <= 1'b1;
               end
            end
            // Received bytes are dropped here
            SEND:
               if (i_tx_done)
                  state_reg <= WAIT_A;
            default:
               state_reg <= WAIT_A;
         endcase
      end
   end

   ////////////////////
   // Operand and result registers

   always_ff @(posedge i_clk)
   begin
      if (i_rx_done && (state_reg == WAIT_A))
         o_a <= i_rx_data;
      if (i_rx_done && (state_reg == WAIT_B))
         o_b <= i_rx_data;
      if (i_rx_done && (state_reg == WAIT_OP))
         o_op <= rx_op;
      // ALU output has settled from the stored opcode
      if (load_reg)
         o_tx_data <= i_result;
   end

endmodule

// File: design/baud_tick_gen.sv
module baud_tick_gen
   import uart_alu_pkg::*;
(
   input  logic i_clk,
   input  logic i_rst,
   output logic o_tick
);

   logic [BAUD_CNT_W-1:0] cnt_reg;
   logic                  cnt_wrap;

   // Last count of the divider period
   assign cnt_wrap = (cnt_reg == BAUD_CNT_W'(BAUD_DIV - 1));

   always_ff @(posedge i_clk)
   begin
      if (!i_rst)
         cnt_reg <= '0;
      else if (cnt_wrap)
         cnt_reg <= '0;
      else
         cnt_reg <= cnt_reg + 1'b1;
   end

   // One clock wide, once per divider period
   assign o_tick = cnt_wrap;

endmodule

// File: design/uart_alu_pkg.sv
package uart_alu_pkg;

   ////////////////////
   // Frame and baud constants

   localparam int NB_DATA    = 8;
   localparam int SB_TICK    = 16;
   localparam int OVERSAMPLE = 16;
   localparam int BAUD_DIV   = 4;

   // Mid-bit point of the start bit in baud ticks
   localparam int MID_TICK   = OVERSAMPLE / 2 - 1;

   // Counter widths
   localparam int TICK_CNT_W = $clog2(OVERSAMPLE);
   localparam int BIT_CNT_W  = $clog2(NB_DATA);
   localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

   // Opcode field width
   localparam int NB_OP      = 6;

   ////////////////////
   // State and opcode types

   typedef enum logic [1:0] {
      IDLE  = 2'b00,
      START = 2'b01,
      DATA  = 2'b10,
      STOP  = 2'b11
   } uart_state_e;

   typedef enum logic [1:0] {
      WAIT_A  = 2'b00,
      WAIT_B  = 2'b01,
      WAIT_OP = 2'b10,
      SEND    = 2'b11
   } iface_state_e;

   // MIPS function codes
   typedef enum logic [NB_OP-1:0] {
      OP_ADD = 6'b100000,
      OP_SUB = 6'b100010,
      OP_AND = 6'b100100,
      OP_OR  = 6'b100101,
      OP_XOR = 6'b100110,
      OP_NOR = 6'b100111,
      OP_SRA = 6'b000011,
      OP_SRL = 6'b000010
   } alu_op_e;

endpackage

// File: design/uart_alu_top.sv
module uart_alu_top
   import uart_alu_pkg::*;
(
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_rx,
   output logic o_tx
);

   logic               tick;
   logic               rx_done;
   logic [NB_DATA-1:0] rx_data;
   logic [NB_DATA-1:0] operand_a;
   logic [NB_DATA-1:0] operand_b;
   alu_op_e            opcode;
   logic [NB_DATA-1:0] result;
   logic               tx_start;
   logic [NB_DATA-1:0] tx_data;
   logic               tx_done;

   baud_tick_gen u_baud_tick_gen (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .o_tick (tick)
   );

   uart_rx u_uart_rx (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_tick    (tick),
      .i_rx      (i_rx),
      .o_rx_done (rx_done),
      .o_rx_data (rx_data)
   );

   alu_interface u_alu_interface (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rx_done  (rx_done),
      .i_rx_data  (rx_data),
      .i_result   (result),
      .i_tx_done  (tx_done),
      .o_a        (operand_a),
      .o_b        (operand_b),
      .o_op       (opcode),
      .o_tx_start (tx_start),
      .o_tx_data  (tx_data)
   );

   alu u_alu (
      .i_a      (operand_a),
      .i_b      (operand_b),
      .i_op     (opcode),
      .o_result (result)
   );

   uart_tx u_uart_tx (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_tx_start (tx_start),
      .i_tick     (tick),
      .i_data     (tx_data),
      .o_done_tx  (tx_done),
      .o_tx       (o_tx)
   );

endmodule

// File: design/uart_rx.sv
module uart_rx
   import uart_alu_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_tick,
   input  logic               i_rx,
   output logic               o_rx_done,
   output logic [NB_DATA-1:0] o_rx_data
);

   uart_state_e            state_reg;
   uart_state_e            state_next;
   logic [TICK_CNT_W-1:0]  s_reg;
   logic [TICK_CNT_W-1:0]  s_next;
   logic [BIT_CNT_W-1:0]   n_reg;
   logic [BIT_CNT_W-1:0]   n_next;
   logic [NB_DATA-1:0]     b_reg;
   logic [NB_DATA-1:0]     b_next;

   ////////////////////
   // State registers

   always_ff @(posedge i_clk)
   begin
      if (!i_rst)
      begin
         state_reg <= IDLE;
         s_reg     <= '0;
         n_reg     <= '0;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
      end
   end

   // Shift register
   always_ff @(posedge i_clk)
   begin
      b_reg <= b_next;
   end

   ////////////////////
   // Next state logic

   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      o_rx_done  = 1'b0;

      case (state_reg)
         IDLE:
         begin
            // Falling edge of the start bit
            if (!i_rx)
            begin
               state_next = START;
               s_next     = '0;
            end
         end
         START:
         begin
            if (i_tick)
            begin
               if (s_reg == TICK_CNT_W'(MID_TICK))
               begin
                  // Line back high at mid-bit means a glitch
                  state_next = i_rx ? IDLE : DATA;
                  s_next     = '0;
                  n_next     = '0;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         DATA:
         begin
            if (i_tick)
            begin
               if (s_reg == TICK_CNT_W'(OVERSAMPLE - 1))
               begin
                  s_next = '0;
                  // First bit in ends up at bit 0
                  b_next = {i_rx, b_reg[NB_DATA-1:1]};
                  if (n_reg == BIT_CNT_W'(NB_DATA - 1))
                     state_next = STOP;
                  else
                     n_next = n_reg + 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         STOP:
         begin
            if (i_tick)
            begin
               if (s_reg == TICK_CNT_W'(SB_TICK - 1))
               begin
                  state_next = IDLE;
                  o_rx_done  = 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         default:
            state_next = IDLE;
      endcase
   end

   assign o_rx_data = b_reg;

endmodule

// File: design/uart_tx.sv
module uart_tx
   import uart_alu_pkg::*;
(
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_tx_start,
   input  logic               i_tick,
   input  logic [NB_DATA-1:0] i_data,
   output logic               o_done_tx,
   output logic               o_tx
);

   uart_state_e            state_reg;
   uart_state_e            state_next;
   logic [TICK_CNT_W-1:0]  s_reg;
   logic [TICK_CNT_W-1:0]  s_next;
   logic [BIT_CNT_W-1:0]   n_reg;
   logic [BIT_CNT_W-1:0]   n_next;
   logic [NB_DATA-1:0]     b_reg;
   logic [NB_DATA-1:0]     b_next;
   logic                   tx_reg;
   logic                   tx_next;

   ////////////////////
   // State registers

   always_ff @(posedge i_clk)
   begin
      if (!i_rst)
      begin
         state_reg <= IDLE;
         s_reg     <= '0;
         n_reg     <= '0;
         tx_reg    <= 1'b1;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         tx_reg    <= tx_next;
      end
   end

   always_ff @(posedge i_clk)
   begin
      b_reg <= b_next;
   end

   ////////////////////
   // Next state logic

   // Line level is set on the transition so it changes one clock after the tick
   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      tx_next    = tx_reg;
      o_done_tx  = 1'b0;

      case (state_reg)
         IDLE:
         begin
            tx_next = 1'b1;
            if (i_tx_start)
            begin
               state_next = START;
               s_next     = '0;
               b_next     = i_data;
               tx_next    = 1'b0;
            end
         end
         START:
         begin
            if (i_tick)
            begin
               if (s_reg == TICK_CNT_W'(OVERSAMPLE - 1))
               begin
                  state_next = DATA;
                  s_next     = '0;
                  n_next     = '0;
                  tx_next    = b_reg[0];
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         DATA:
         begin
            if (i_tick)
            begin
               if (s_reg == TICK_CNT_W'(OVERSAMPLE - 1))
               begin
                  s_next = '0;
                  b_next = b_reg >> 1;
                  if (n_reg == BIT_CNT_W'(NB_DATA - 1))
                  begin
                     state_next = STOP;
                     tx_next    = 1'b1;
                  end
                  else
                  begin
                     n_next  = n_reg + 1'b1;
                     tx_next = b_reg[1];
                  end
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         STOP:
         begin
            if (i_tick)
            begin
               if (s_reg == TICK_CNT_W'(SB_TICK - 1))
               begin
                  state_next = IDLE;
                  o_done_tx  = 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         end
         default:
            state_next = IDLE;
      endcase
   end

   assign o_tx = tx_reg;

endmodule

// File: filelist.f
design/uart_alu_pkg.sv
design/baud_tick_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/alu.sv
design/alu_interface.sv
design/uart_alu_top.sv
verif/uart_alu_checker.sv
verif/tb_uart_alu.sv

// File: verif/tb_uart_alu.sv
module tb_uart_alu
   import uart_alu_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int BIT_CLKS     = BAUD_DIV * OVERSAMPLE;
   localparam int EDGE_TIMEOUT = 4 * (NB_DATA + 2) * BIT_CLKS;

   logic        i_clk          = 1'b0;
   logic        i_rst          = 1'b0;
   logic        i_rx           = 1'b1;
   logic        o_tx;
   logic [15:0] lfsr_state     = 16'h0001;
   logic        result_started = 1'b0;
   int          assert_fails;
   alu_op_e     op_table [8]   = '{OP_ADD, OP_SUB, OP_AND, OP_OR,
                                   OP_XOR, OP_NOR, OP_SRA, OP_SRL};

   always #10 i_clk = ~i_clk;

   uart_alu_top u_dut (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .i_rx  (i_rx),
      .o_tx  (o_tx)
   );

   // Failures of the bound assertions in both UART blocks
   assign assert_fails = u_dut.u_uart_tx.u_tx_checker.fail_count +
                         u_dut.u_uart_rx.u_rx_checker.fail_count;

   ////////////////////
   // Reference and random source

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      logic feedback;
      feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
      return {state[14:0], feedback};
   endfunction

   task automatic draw_bits(input int count, output logic [NB_DATA-1:0] value);
      value = '0;
      for (int i = 0; i < count; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = {value[NB_DATA-2:0], lfsr_state[0]};
      end
   endtask

   function automatic logic [NB_DATA-1:0] alu_model(input logic [NB_DATA-1:0] a,
                                                    input logic [NB_DATA-1:0] b,
                                                    input logic [NB_DATA-1:0] op_byte);
      logic [NB_DATA-1:0] r;
      int                 shift;
      shift = b % 8;
      case (op_byte)
         NB_DATA'(OP_ADD): r = a + b;
         NB_DATA'(OP_SUB): r = a - b;
         NB_DATA'(OP_AND): r = a & b;
         NB_DATA'(OP_OR):  r = a | b;
         NB_DATA'(OP_XOR): r = a ^ b;
         NB_DATA'(OP_NOR): r = ~(a | b);
         NB_DATA'(OP_SRA):
         begin
            r = a;
            repeat (shift) r = {r[NB_DATA-1], r[NB_DATA-1:1]};
         end
         NB_DATA'(OP_SRL):
         begin
            r = a;
            repeat (shift) r = {1'b0, r[NB_DATA-1:1]};
         end
         default: r = '0;
      endcase
      return r;
   endfunction

   ////////////////////
   // Checks

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("Simulation failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_byte(input string name, input logic [NB_DATA-1:0] expected,
                             input logic [NB_DATA-1:0] actual);
      if (actual !== expected)
         stop_on_error($sformatf("CHECK FAILED time=%0t %s expected=%h actual=%h",
                                 $time, name, expected, actual));
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         stop_on_error($sformatf("CHECK FAILED time=%0t %s expected=%b actual=%b",
                                 $time, name, expected, actual));
   endtask

   // Bound assertion failures end the run at once
   always @(negedge i_clk)
   begin
      if (assert_fails != 0)
      begin
         $display("Simulation failed");
         $fatal(1, "A bound assertion failed");
      end
   end

   ////////////////////
   // Serial driver and monitor

   // Called right after a rising edge
   task automatic send_byte(input logic [NB_DATA-1:0] data, input logic hold_for_result);
      int waited;
      i_rx <= 1'b0;
      repeat (BIT_CLKS) @(posedge i_clk);
      for (int i = 0; i < NB_DATA; i++)
      begin
         i_rx <= data[i];
         repeat (BIT_CLKS) @(posedge i_clk);
      end
      i_rx <= 1'b1;
      if (hold_for_result)
      begin
         // Stop bit ends as soon as the result frame begins
         waited = 0;
         @(posedge i_clk);
         while (!result_started)
         begin
            waited++;
            if (waited > BIT_CLKS)
               stop_on_error("Timeout: result start bit not seen during the opcode stop bit");
            @(posedge i_clk);
         end
      end
      else
         repeat (BIT_CLKS) @(posedge i_clk);
   endtask

   task automatic capture_byte(output logic [NB_DATA-1:0] data, output logic stop_bit);
      logic prev;
      int   waited;
      result_started = 1'b0;
      waited         = 0;
      prev           = o_tx;
      @(negedge i_clk);
      while (!((prev === 1'b1) && (o_tx === 1'b0)))
      begin
         prev = o_tx;
         waited++;
         if (waited > EDGE_TIMEOUT)
            stop_on_error("Timeout: no start bit appeared on o_tx");
         @(negedge i_clk);
      end
      result_started = 1'b1;
      // Middle of the start bit
      repeat (BIT_CLKS / 2 - 1) @(negedge i_clk);
      check_bit("o_tx start bit", 1'b0, o_tx);
      for (int i = 0; i < NB_DATA; i++)
      begin
         repeat (BIT_CLKS) @(negedge i_clk);
         data[i] = o_tx;
      end
      repeat (BIT_CLKS) @(negedge i_clk);
      stop_bit = o_tx;
   endtask

   task automatic run_command(input logic [NB_DATA-1:0] a, input logic [NB_DATA-1:0] b,
                              input logic [NB_DATA-1:0] op);
      logic [NB_DATA-1:0] got;
      logic               stop;
      fork
         begin
            send_byte(a, 1'b0);
            send_byte(b, 1'b0);
            send_byte(op, 1'b0);
         end
         begin
            capture_byte(got, stop);
            check_byte("o_tx result", alu_model(a, b, op), got);
            check_bit("o_tx stop bit", 1'b1, stop);
         end
      join
      // Rest of the result stop bit
      repeat (BIT_CLKS / 2) @(posedge i_clk);
   endtask

   // One extra byte lands while the result is on the line
   task automatic drop_during_result(input logic [NB_DATA-1:0] a,
                                     input logic [NB_DATA-1:0] b,
                                     input logic [NB_DATA-1:0] op,
                                     input logic [NB_DATA-1:0] extra);
      logic [NB_DATA-1:0] got;
      logic               stop;
      fork
         begin
            send_byte(a, 1'b0);
            send_byte(b, 1'b0);
            send_byte(op, 1'b1);
            send_byte(extra, 1'b0);
         end
         begin
            capture_byte(got, stop);
            check_byte("o_tx result", alu_model(a, b, op), got);
            check_bit("o_tx stop bit", 1'b1, stop);
         end
      join
   endtask

   task automatic run_random(input int gap);
      logic [NB_DATA-1:0] a;
      logic [NB_DATA-1:0] b;
      logic [NB_DATA-1:0] idx;
      draw_bits(NB_DATA, a);
      draw_bits(NB_DATA, b);
      draw_bits(3, idx);
      run_command(a, b, NB_DATA'(op_table[idx[2:0]]));
      repeat (gap) @(posedge i_clk);
   endtask

   ////////////////////
   // Test sequence

   initial
   begin
      repeat (5) @(posedge i_clk);
      i_rst <= 1'b1;
      @(posedge i_clk);

      // Idle line after reset
      repeat (200)
      begin
         @(negedge i_clk);
         check_bit("o_tx idle", 1'b1, o_tx);
      end
      @(posedge i_clk);

      // Each opcode with fixed operands
      run_command(8'd200, 8'd100, NB_DATA'(OP_ADD));
      run_command(8'd5, 8'd10, NB_DATA'(OP_SUB));
      run_command(8'hC3, 8'h5A, NB_DATA'(OP_AND));
      run_command(8'hC3, 8'h5A, NB_DATA'(OP_OR));
      run_command(8'hC3, 8'h5A, NB_DATA'(OP_XOR));
      run_command(8'hC3, 8'h18, NB_DATA'(OP_NOR));
      run_command(8'h90, 8'h0B, NB_DATA'(OP_SRA));
      run_command(8'h90, 8'h0B, NB_DATA'(OP_SRL));

      for (int i = 0; i < 50; i++)
         run_random(20);

      // Undefined codes
      run_command(8'h5A, 8'h33, 8'hFF);
      run_command(8'h5A, 8'h33, 8'h21);
      run_command(8'h5A, 8'h33, 8'hE0);

      drop_during_result(8'h12, 8'h34, NB_DATA'(OP_ADD), 8'h77);
      run_command(8'h81, 8'h02, NB_DATA'(OP_SRA));

      // Back to back with no gap after each stop bit
      for (int i = 0; i < 5; i++)
         run_random(0);

      @(negedge i_clk);
      if (assert_fails == 0)
      begin
         $display("Simulation completed successfully");
         $finish;
      end
      else
      begin
         $display("Simulation failed");
         $fatal(1, "A bound assertion failed");
      end
   end

endmodule

// File: verif/uart_alu_checker.sv
module uart_alu_checker
   import uart_alu_pkg::*;
(
   input logic        i_clk,
   input logic        i_rst,
   input logic        i_tick,
   input logic        i_start,
   input uart_state_e i_state,
   input logic        i_line,
   input logic        i_done,
   input logic        i_drives_line
);

   timeunit 1ns;
   timeprecision 1ps;

   // Failed assertions so far
   int fail_count = 0;

   // Transmit line rests high between frames
   a_idle_line_high: assert property (
      @(posedge i_clk) disable iff (!i_rst)
      (i_drives_line && (i_state == IDLE)) |-> i_line
   )
   else
   begin
      $error("Serial line low while the state machine is idle");
      fail_count++;
   end

   // Done strobes are single cycle
   a_done_one_cycle: assert property (
      @(posedge i_clk) disable iff (!i_rst)
      i_done |=> !i_done
   )
   else
   begin
      $error("Done pulse longer than one clock");
      fail_count++;
   end

   // Line level only moves one clock after a tick or a start
   a_line_on_tick: assert property (
      @(posedge i_clk) disable iff (!i_rst)
      (i_drives_line && $changed(i_line)) |-> ($past(i_tick) || $past(i_start))
   )
   else
   begin
      $error("Serial line changed without a tick or a start");
      fail_count++;
   end

endmodule

bind uart_tx uart_alu_checker u_tx_checker (
   .i_clk         (i_clk),
   .i_rst         (i_rst),
   .i_tick        (i_tick),
   .i_start       (i_tx_start),
   .i_state       (state_reg),
   .i_line        (o_tx),
   .i_done        (o_done_tx),
   .i_drives_line (1'b1)
);

bind uart_rx uart_alu_checker u_rx_checker (
   .i_clk         (i_clk),
   .i_rst         (i_rst),
   .i_tick        (i_tick),
   .i_start       (1'b0),
   .i_state       (state_reg),
   .i_line        (i_rx),
   .i_done        (o_rx_done),
   .i_drives_line (1'b0)
);
